//--- src/scope_pkg.sv
package scope_pkg;

  //////////////////////////////
  // Basic types
  //////////////////////////////

  typedef logic [7:0] sample_t;  // Unsigned ADC code
  typedef logic [9:0] addr_t;

  // Frame memory write, one sample per cycle
  typedef struct packed {
    logic    en;
    logic    last;  // Final sample of the frame
    addr_t   adr;
    sample_t dat;
  } ram_wr_t;

  // Wishbone classic read request, no write side
  typedef struct packed {
    logic  cyc;
    logic  stb;
    addr_t adr;
  } wb_req_t;

  typedef struct packed {
    logic    ack;
    sample_t dat;
  } wb_rsp_t;

  typedef struct packed {
    logic [3:0] hundreds;
    logic [3:0] tens;
    logic [3:0] units;
  } vopp_digits_t;

  //////////////////////////////
  // Fixed levels
  //////////////////////////////

  localparam sample_t     SEED_LEVEL = 8'd112;  // Start of each peak search
  localparam int unsigned VOPP_SCALE = 4;
  localparam sample_t     VOPP_SAT   = 8'd250;  // Display shows 999 from here up

endpackage

//--- src/capture_ctrl.sv
`timescale 1ns/1ps

module capture_ctrl #(
  parameter int FRAME_LEN  = 640,
  parameter int TRIG_LEVEL = 128
) (
  input  logic                clk_AD,
  input  logic                reset,
  input  scope_pkg::sample_t  data_in,
  input  logic                trigger,
  output scope_pkg::ram_wr_t  ram_wr,
  output logic                capturing
);

  scope_pkg::addr_t wr_adr;
  logic             trig_ok;
  logic             last_wr;

  // Trigger only counts while idle and with the sample at or above the level
  assign trig_ok = !capturing && trigger &&
                   (data_in >= scope_pkg::sample_t'(TRIG_LEVEL));

  assign last_wr = capturing && (wr_adr == scope_pkg::addr_t'(FRAME_LEN - 1));

  //////////////////////////////
  // State and address counter
  //////////////////////////////

  always_ff @(posedge clk_AD) begin
    if (reset) begin
      capturing <= 1'b0;
      wr_adr    <= '0;
    end else if (trig_ok) begin
      capturing <= 1'b1;
      wr_adr    <= '0;  // Trigger sample itself is dropped
    end else if (capturing) begin
      wr_adr <= wr_adr + 1'b1;
      if (last_wr) begin
        capturing <= 1'b0;  // Back to idle, wait for next trigger
      end
    end
  end

  // Write carries the live sample
  always_comb begin
    ram_wr.en   = capturing;
    ram_wr.last = last_wr;
    ram_wr.adr  = wr_adr;
    ram_wr.dat  = data_in;
  end

endmodule

//--- src/wave_ram.sv
`timescale 1ns/1ps

module wave_ram #(
  parameter int FRAME_LEN = 640
) (
  input  logic                clk_AD,
  input  logic                reset,
  input  scope_pkg::ram_wr_t  ram_wr,
  input  scope_pkg::wb_req_t  wb_req,
  output scope_pkg::wb_rsp_t  wb_rsp
);

  scope_pkg::sample_t mem [FRAME_LEN];

  logic               rsp_ack;
  scope_pkg::sample_t rsp_dat;
  logic               rd_req;
  logic               in_frame;

  //////////////////////////////
  // Capture side
  //////////////////////////////

  always_ff @(posedge clk_AD) begin
    if (ram_wr.en) begin
      mem[ram_wr.adr] <= ram_wr.dat;
    end
  end

  //////////////////////////////
  // Wishbone read side
  //////////////////////////////

  // New request only, so ack lasts a single cycle
  assign rd_req   = wb_req.cyc && wb_req.stb && !rsp_ack;
  assign in_frame = (wb_req.adr < scope_pkg::addr_t'(FRAME_LEN));

  always_ff @(posedge clk_AD) begin
    if (reset) begin
      rsp_ack <= 1'b0;
    end else begin
      rsp_ack <= rd_req;
    end
  end

  always_ff @(posedge clk_AD) begin
    if (rd_req) begin
      rsp_dat <= in_frame ? mem[wb_req.adr] : '0;  // Past the frame reads zero
    end
  end

  always_comb begin
    wb_rsp.ack = rsp_ack;
    wb_rsp.dat = rsp_dat;
  end

endmodule

//--- src/peak_tracker.sv
`timescale 1ns/1ps

module peak_tracker (
  input  logic                clk_AD,
  input  logic                reset,
  input  scope_pkg::ram_wr_t  ram_wr,
  output scope_pkg::sample_t  vopp
);

  scope_pkg::sample_t max_reg;
  scope_pkg::sample_t min_reg;
  scope_pkg::sample_t max_nxt;
  scope_pkg::sample_t min_nxt;

  // Running extremes including the sample being written now
  always_comb begin
    max_nxt = (ram_wr.dat > max_reg) ? ram_wr.dat : max_reg;
    min_nxt = (ram_wr.dat < min_reg) ? ram_wr.dat : min_reg;
  end

  //////////////////////////////
  // Peak registers
  //////////////////////////////

  always_ff @(posedge clk_AD) begin
    if (reset) begin
      max_reg <= scope_pkg::SEED_LEVEL;
      min_reg <= scope_pkg::SEED_LEVEL;
      vopp    <= '0;
    end else if (ram_wr.en) begin
      if (ram_wr.last) begin
        vopp    <= max_nxt - min_nxt;  // Never negative, max starts at min
        max_reg <= scope_pkg::SEED_LEVEL;
        min_reg <= scope_pkg::SEED_LEVEL;
      end else begin
        max_reg <= max_nxt;
        min_reg <= min_nxt;
      end
    end
  end

endmodule

//--- src/vopp_display.sv
`timescale 1ns/1ps

module vopp_display #(
  parameter int REFRESH_CYCLES = 64
) (
  input  logic                     clk_AD,
  input  logic                     reset,
  input  scope_pkg::sample_t       vopp,
  output scope_pkg::vopp_digits_t  vopp_digits
);

  localparam int CNT_W = (REFRESH_CYCLES > 1) ? $clog2(REFRESH_CYCLES) : 1;

  logic [CNT_W-1:0]       refresh_cnt;
  logic                   tick;
  logic [9:0]             scaled;  // Up to 249 * 4
  scope_pkg::vopp_digits_t digits_nxt;

  // Shift-and-add-3 conversion of a 10 bit value
  function automatic scope_pkg::vopp_digits_t to_bcd(input logic [9:0] bin);
    logic [21:0]             sr;
    scope_pkg::vopp_digits_t d;
    sr = {12'd0, bin};
    for (int i = 0; i < 10; i++) begin
      if (sr[13:10] >= 4'd5) sr[13:10] = sr[13:10] + 4'd3;
      if (sr[17:14] >= 4'd5) sr[17:14] = sr[17:14] + 4'd3;
      if (sr[21:18] >= 4'd5) sr[21:18] = sr[21:18] + 4'd3;
      sr = sr << 1;
    end
    d.hundreds = sr[21:18];
    d.tens     = sr[17:14];
    d.units    = sr[13:10];
    return d;
  endfunction

  //////////////////////////////
  // Refresh tick
  //////////////////////////////

  assign tick = (refresh_cnt == CNT_W'(REFRESH_CYCLES - 1));

  always_ff @(posedge clk_AD) begin
    if (reset || tick) begin
      refresh_cnt <= '0;
    end else begin
      refresh_cnt <= refresh_cnt + 1'b1;
    end
  end

  //////////////////////////////
  // Scaling and digits
  //////////////////////////////

  assign scaled = 10'(vopp * scope_pkg::VOPP_SCALE);

  always_comb begin
    if (vopp >= scope_pkg::VOPP_SAT) begin
      digits_nxt.hundreds = 4'd9;  // Saturated reading
      digits_nxt.tens     = 4'd9;
      digits_nxt.units    = 4'd9;
    end else begin
      digits_nxt = to_bcd(scaled);
    end
  end

  always_ff @(posedge clk_AD) begin
    if (reset) begin
      vopp_digits <= '0;
    end else if (tick) begin
      vopp_digits <= digits_nxt;
    end
  end

endmodule

//--- src/scope_capture.sv
`timescale 1ns/1ps

module scope_capture #(
  parameter int FRAME_LEN      = 640,  // At most 1023
  parameter int TRIG_LEVEL     = 128,
  parameter int REFRESH_CYCLES = 64
) (
  input  logic                     clk_AD,
  input  logic                     reset,
  input  scope_pkg::sample_t       data_in,
  input  logic                     trigger,
  input  scope_pkg::wb_req_t       wb_req,
  output scope_pkg::wb_rsp_t       wb_rsp,
  output logic                     capturing,
  output scope_pkg::vopp_digits_t  vopp_digits
);

  scope_pkg::ram_wr_t ram_wr;  // Shared by memory and peak search
  scope_pkg::sample_t vopp;

  //////////////////////////////
  // Capture path
  //////////////////////////////

  capture_ctrl #(
    .FRAME_LEN  (FRAME_LEN),
    .TRIG_LEVEL (TRIG_LEVEL)
  ) i_capture_ctrl (
    .clk_AD    (clk_AD),
    .reset     (reset),
    .data_in   (data_in),
    .trigger   (trigger),
    .ram_wr    (ram_wr),
    .capturing (capturing)
  );

  wave_ram #(
    .FRAME_LEN (FRAME_LEN)
  ) i_wave_ram (
    .clk_AD (clk_AD),
    .reset  (reset),
    .ram_wr (ram_wr),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  //////////////////////////////
  // Measurement path
  //////////////////////////////

  peak_tracker i_peak_tracker (
    .clk_AD (clk_AD),
    .reset  (reset),
    .ram_wr (ram_wr),
    .vopp   (vopp)
  );

  vopp_display #(
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) i_vopp_display (
    .clk_AD      (clk_AD),
    .reset       (reset),
    .vopp        (vopp),
    .vopp_digits (vopp_digits)
  );

endmodule

//--- testbench/scope_props.sv
`timescale 1ns/1ps

module scope_props (
  input logic                    clk_AD,
  input logic                    reset,
  input scope_pkg::wb_req_t      wb_req,
  input scope_pkg::wb_rsp_t      wb_rsp,
  input scope_pkg::vopp_digits_t vopp_digits
);

  //////////////////////////////
  // Wishbone read port
  //////////////////////////////

  ack_only_on_request: assert property (@(posedge clk_AD) disable iff (reset)
    wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
    else $error("Wishbone ack without cyc and stb");

  ack_single_cycle: assert property (@(posedge clk_AD) disable iff (reset)
    wb_rsp.ack |=> !wb_rsp.ack)
    else $error("Wishbone ack high for two cycles");

  // BCD digits
  digits_in_range: assert property (@(posedge clk_AD) disable iff (reset)
    (vopp_digits.hundreds <= 4'd9) && (vopp_digits.tens <= 4'd9) &&
    (vopp_digits.units <= 4'd9))
    else $error("Display digit above 9");

endmodule

bind scope_capture scope_props i_scope_props (
  .clk_AD      (clk_AD),
  .reset       (reset),
  .wb_req      (wb_req),
  .wb_rsp      (wb_rsp),
  .vopp_digits (vopp_digits)
);

//--- testbench/scope_checker.sv
`timescale 1ns/1ps

module scope_checker #(
  parameter int FRAME_LEN      = 640,
  parameter int TRIG_LEVEL     = 128,
  parameter int REFRESH_CYCLES = 64
) (
  input  logic                    clk_AD,
  input  logic                    reset,
  input  scope_pkg::sample_t      data_in,
  input  logic                    trigger,
  input  scope_pkg::wb_req_t      wb_req,
  input  scope_pkg::wb_rsp_t      wb_rsp,
  input  logic                    capturing,
  input  scope_pkg::vopp_digits_t vopp_digits,
  input  logic                    digit_check,
  output int                      errors
);

  scope_pkg::sample_t      model_mem [1024];
  scope_pkg::sample_t      exp_dat;
  logic                    model_cap;
  logic                    prev_ack;
  int                      model_adr;
  int                      model_max;
  int                      model_min;
  int                      model_vopp;
  int                      tick_cnt;
  scope_pkg::vopp_digits_t model_digits;  // Model of the display register
  scope_pkg::vopp_digits_t last_digits;
  scope_pkg::vopp_digits_t want;

  // Difference times four in decimal, capped at 999
  function automatic scope_pkg::vopp_digits_t expected_digits(input int v);
    int                      n;
    scope_pkg::vopp_digits_t d;
    n = v * scope_pkg::VOPP_SCALE;
    if (v >= scope_pkg::VOPP_SAT) n = 999;
    d.hundreds = 4'(n / 100);
    d.tens     = 4'((n / 10) % 10);
    d.units    = 4'(n % 10);
    return d;
  endfunction

  initial errors = 0;

  always @(posedge clk_AD) begin
    if (reset) begin
      model_cap    = 1'b0;
      prev_ack     = 1'b0;
      model_adr    = 0;
      model_max    = scope_pkg::SEED_LEVEL;
      model_min    = scope_pkg::SEED_LEVEL;
      model_vopp   = 0;
      tick_cnt     = 0;
      model_digits = '0;
      last_digits  = '0;
    end else begin
      //////////////////////////////
      // Compare against model state
      //////////////////////////////
      if (capturing !== model_cap) begin
        $display("FAILED at %0t: capturing expected %b got %b", $time, model_cap, capturing);
        errors++;
      end
      if (wb_rsp.ack) begin
        if (!(wb_req.cyc && wb_req.stb)) begin
          $display("At %0t ack came without an active request", $time);
          errors++;
        end
        if (prev_ack) begin
          $display("At %0t ack stayed high for two cycles", $time);
          errors++;
        end
        exp_dat = (wb_req.adr < FRAME_LEN) ? model_mem[wb_req.adr] : '0;
        if (wb_rsp.dat !== exp_dat) begin
          $display("FAILED at %0t: wb_rsp.dat (adr %0d) expected %0h got %0h",
                   $time, wb_req.adr, exp_dat, wb_rsp.dat);
          errors++;
        end
      end
      prev_ack = wb_rsp.ack;
      if (vopp_digits !== last_digits) begin
        if (vopp_digits !== model_digits) begin
          $display("FAILED at %0t: vopp_digits expected %h got %h",
                   $time, model_digits, vopp_digits);
          errors++;
        end
        last_digits = vopp_digits;
      end
      want = expected_digits(model_vopp);
      if (digit_check && vopp_digits !== want) begin
        $display("FAILED at %0t: vopp_digits expected %h got %h", $time, want, vopp_digits);
        errors++;
      end
      //////////////////////////////
      // Advance the model
      //////////////////////////////
      if (tick_cnt == REFRESH_CYCLES - 1) begin
        tick_cnt     = 0;
        model_digits = expected_digits(model_vopp);  // Old vopp at the tick
      end else begin
        tick_cnt++;
      end
      if (model_cap) begin
        model_mem[model_adr] = data_in;
        if (data_in > model_max) model_max = data_in;
        if (data_in < model_min) model_min = data_in;
        if (model_adr == FRAME_LEN - 1) begin
          model_vopp = model_max - model_min;
          model_max  = scope_pkg::SEED_LEVEL;
          model_min  = scope_pkg::SEED_LEVEL;
          model_cap  = 1'b0;
        end
        model_adr++;
      end else if (trigger && data_in >= TRIG_LEVEL) begin
        model_cap = 1'b1;
        model_adr = 0;  // Trigger sample not stored
      end
    end
  end

endmodule

//--- testbench/scope_capture_tb.sv
`timescale 1ns/1ps

module scope_capture_tb;

  localparam int FRAME_LEN      = 640;
  localparam int TRIG_LEVEL     = 128;
  localparam int REFRESH_CYCLES = 64;
  localparam int NUM_TESTS      = 5;
  localparam int CYCLE_LIMIT    = NUM_TESTS * (FRAME_LEN + 2 * REFRESH_CYCLES + 700) * 2;

  logic                    clk_AD;
  logic                    reset;
  scope_pkg::sample_t      data_in;
  logic                    trigger;
  scope_pkg::wb_req_t      wb_req;
  scope_pkg::wb_rsp_t      wb_rsp;
  logic                    capturing;
  scope_pkg::vopp_digits_t vopp_digits;
  logic                    digit_check;  // Asks the checker for a settled digit compare
  int                      checker_errors;
  int                      tb_errors;
  int                      cycles;
  int                      errs_mark;
  int                      tests_failed;

  scope_capture #(
    .FRAME_LEN      (FRAME_LEN),
    .TRIG_LEVEL     (TRIG_LEVEL),
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) i_scope_capture (
    .clk_AD      (clk_AD),
    .reset       (reset),
    .data_in     (data_in),
    .trigger     (trigger),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .capturing   (capturing),
    .vopp_digits (vopp_digits)
  );

  scope_checker #(
    .FRAME_LEN      (FRAME_LEN),
    .TRIG_LEVEL     (TRIG_LEVEL),
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) i_scope_checker (
    .clk_AD      (clk_AD),
    .reset       (reset),
    .data_in     (data_in),
    .trigger     (trigger),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .capturing   (capturing),
    .vopp_digits (vopp_digits),
    .digit_check (digit_check),
    .errors      (checker_errors)
  );

  initial begin
    clk_AD = 1'b0;
    forever #20 clk_AD = ~clk_AD;
  end

  //////////////////////////////
  // Timeout
  //////////////////////////////

  always @(posedge clk_AD) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic send_sample(input int s, input logic trg);
    @(posedge clk_AD);
    data_in <= scope_pkg::sample_t'(s);
    trigger <= trg;
  endtask

  task automatic expect_idle();
    if (capturing !== 1'b0) begin
      $display("FAILED at %0t: capturing expected 0 got %b", $time, capturing);
      tb_errors++;
    end
  endtask

  task automatic wait_capturing(input logic level, input int limit);
    int n;
    n = 0;
    while (capturing !== level && n < limit) begin
      @(posedge clk_AD);
      n++;
    end
    if (capturing !== level) begin
      $display("At %0t capturing did not go to %b within %0d cycles", $time, level, limit);
      tb_errors++;
    end
  endtask

  // First two samples pin the range ends
  function automatic int frame_sample(input int i, input int lo, input int hi);
    if (i == 0) return lo;
    if (i == 1) return hi;
    return lo + int'($urandom % (hi - lo + 1));
  endfunction

  task automatic capture_frame(input int lo, input int hi, input bit noisy);
    bit seen_high;
    seen_high = 1'b0;
    send_sample(TRIG_LEVEL + int'($urandom % (256 - TRIG_LEVEL)), 1'b1);
    for (int i = 0; i < FRAME_LEN; i++) begin
      send_sample(frame_sample(i, lo, hi), noisy && ($urandom % 4 == 0));
      if (capturing) seen_high = 1'b1;
    end
    send_sample(int'($urandom % TRIG_LEVEL), 1'b0);
    if (!seen_high) begin
      $display("At %0t capturing never went high after a valid trigger", $time);
      tb_errors++;
    end
    wait_capturing(1'b0, 4);
  endtask

  task automatic bus_read(input int adr);
    int n;
    @(posedge clk_AD);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, adr: scope_pkg::addr_t'(adr)};
    n = 0;
    do begin
      @(posedge clk_AD);
      n++;
    end while (!wb_rsp.ack && n < 8);
    wb_req <= '0;  // Drop the strobe right after ack
    if (!wb_rsp.ack) begin
      $display("At %0t no ack for the read of address %0d", $time, adr);
      tb_errors++;
    end
  endtask

  task automatic settle_and_check_digits();
    repeat (REFRESH_CYCLES + 2) @(posedge clk_AD);
    digit_check <= 1'b1;
    @(posedge clk_AD);
    digit_check <= 1'b0;
    @(posedge clk_AD);
  endtask

  task automatic end_test(input int num, input string name);
    int n;
    settle_and_check_digits();
    n = tb_errors + checker_errors - errs_mark;
    $display("Test %0d %s: %0d errors", num, name, n);
    if (n != 0) tests_failed++;
    errs_mark = tb_errors + checker_errors;
  endtask

  task automatic read_frame_shuffled();
    int order [FRAME_LEN];
    int j;
    int t;
    for (int i = 0; i < FRAME_LEN; i++) order[i] = i;
    for (int i = FRAME_LEN - 1; i > 0; i--) begin
      j = int'($urandom % (i + 1));
      t = order[i];
      order[i] = order[j];
      order[j] = t;
    end
    for (int i = 0; i < FRAME_LEN; i++) bus_read(order[i]);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int lo;
    void'($urandom(32'h263765f6));
    cycles       = 0;
    tb_errors    = 0;
    errs_mark    = 0;
    tests_failed = 0;
    reset        = 1'b1;
    data_in      = '0;
    trigger      = 1'b0;
    wb_req       = '0;
    digit_check  = 1'b0;
    repeat (3) @(posedge clk_AD);
    reset <= 1'b0;

    repeat (6) begin
      @(posedge clk_AD);
      expect_idle();
      if (vopp_digits !== '0) begin
        $display("FAILED at %0t: vopp_digits expected 000 got %h", $time, vopp_digits);
        tb_errors++;
      end
    end
    end_test(1, "reset");

    // Trigger high below the level, then above the level with trigger low
    repeat (40) begin
      send_sample(int'($urandom % TRIG_LEVEL), 1'b1);
      expect_idle();
    end
    repeat (40) begin
      send_sample(TRIG_LEVEL + int'($urandom % (256 - TRIG_LEVEL)), 1'b0);
      expect_idle();
    end
    send_sample(0, 1'b0);
    expect_idle();
    capture_frame(0, 255, 1'b0);
    end_test(2, "trigger gating");

    capture_frame(0, 255, 1'b1);  // Extra triggers inside the frame
    read_frame_shuffled();
    end_test(3, "frame content");

    bus_read(FRAME_LEN);
    bus_read(1023);
    repeat (60) bus_read(FRAME_LEN + int'($urandom % (1024 - FRAME_LEN)));
    end_test(4, "out-of-range reads");

    capture_frame(100, 140, 1'b0);
    settle_and_check_digits();
    capture_frame(0, 255, 1'b0);
    settle_and_check_digits();
    capture_frame(30, 90, 1'b0);
    settle_and_check_digits();
    lo = int'($urandom % 200);
    capture_frame(lo, lo + int'($urandom % (256 - lo)), 1'b0);
    settle_and_check_digits();
    capture_frame(120, 125, 1'b0);
    end_test(5, "peak-to-peak digits");

    $display("Tests run %0d, tests with errors %0d, total errors %0d",
             NUM_TESTS, tests_failed, tb_errors + checker_errors);
    if (tb_errors + checker_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- scope_capture.f
src/scope_pkg.sv
src/capture_ctrl.sv
src/wave_ram.sv
src/peak_tracker.sv
src/vopp_display.sv
src/scope_capture.sv
testbench/scope_props.sv
testbench/scope_checker.sv
testbench/scope_capture_tb.sv
